// File: Makefile
# Verilator flow for the banked RAM; all variables can be set on the command line
VERILATOR ?= verilator
TOP       ?= tb_banked_ram
RTL_TOP   ?= banked_ram
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert
LINTFLAGS ?= --lint-only -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the log holds the pass line on its own
run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "NO ERRORS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: compile.f
+incdir+include
rtl/ram_types_pkg.sv
rtl/ram_ctrl_pkg.sv
rtl/ram_addr_decoder_stage.sv
rtl/ram_bank.sv
rtl/ram_init_counter.sv
rtl/ram_init_fsm.sv
rtl/ram_read_select.sv
rtl/banked_ram.sv
test/tb_banked_ram.sv

// File: include/ram_params.svh
// Sizes of the banked RAM; bank count must be a power of two and below 2**RAM_ADDR_WIDTH
`ifndef RAM_PARAMS_SVH
`define RAM_PARAMS_SVH

// Full request address, bank select plus offset
`define RAM_ADDR_WIDTH 6

// One stored word
`define RAM_DATA_WIDTH 8

// Bank count, a power of two
`define RAM_BANKS 4

// Derived from the values above
`define RAM_BANK_SEL_WIDTH $clog2(`RAM_BANKS)
`define RAM_OFFSET_WIDTH (`RAM_ADDR_WIDTH - `RAM_BANK_SEL_WIDTH)

// Words per bank
`define RAM_BANK_DEPTH (1 << `RAM_OFFSET_WIDTH)

`endif

// File: rtl/banked_ram.sv
// Banked RAM top; two-cycle reads, requests dropped while ready is low
`timescale 1ns/1ps
`include "ram_params.svh"

module banked_ram (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req_valid,
  input  logic                     req_write,
  input  ram_types_pkg::ram_addr_t req_addr,
  input  ram_types_pkg::ram_data_t req_wdata,
  input  logic                     clear,
  output logic                     ready,
  output logic                     rsp_valid,
  output ram_types_pkg::ram_data_t rsp_rdata
);

  // ------------------------------------------------------------
  // Internal nets
  // ------------------------------------------------------------

  // Sequencer and counter
  logic                       dec_valid;
  logic                       clear_en;
  logic                       clear_last;
  ram_types_pkg::ram_offset_t clear_offset;

  // Decoder outputs, one lane per bank
  logic [`RAM_BANKS-1:0]                       bank_valid;
  ram_types_pkg::ram_offset_t [`RAM_BANKS-1:0] bank_offset;
  logic [`RAM_BANKS-1:0]                       bank_write;
  ram_types_pkg::ram_data_t [`RAM_BANKS-1:0]   bank_wdata;

  // Bank read outputs
  logic [`RAM_BANKS-1:0]                     bank_rd_valid;
  ram_types_pkg::ram_data_t [`RAM_BANKS-1:0] bank_rd_data;

  // Decoded request seen by the selector
  logic                         sel_valid;
  logic                         sel_write;
  ram_types_pkg::ram_bank_sel_t sel_bank;

  // ------------------------------------------------------------
  // Control
  // ------------------------------------------------------------

  ram_init_fsm u_init_fsm (
    .clk       (clk),
    .reset     (reset),
    .clear     (clear),
    .last      (clear_last),
    .req_valid (req_valid),
    .clear_en  (clear_en),
    .ready     (ready),
    .dec_valid (dec_valid)
  );

  ram_init_counter u_init_counter (
    .clk          (clk),
    .reset        (reset),
    .clear_en     (clear_en),
    .clear_offset (clear_offset),
    .last         (clear_last)
  );

  // ------------------------------------------------------------
  // Datapath
  // ------------------------------------------------------------

  ram_addr_decoder_stage u_decoder (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (dec_valid),
    .in_addr    (req_addr),
    .in_write   (req_write),
    .in_wdata   (req_wdata),
    .out_valid  (bank_valid),
    .out_offset (bank_offset),
    .out_write  (bank_write),
    .out_wdata  (bank_wdata)
  );

  for (genvar i = 0; i < `RAM_BANKS; i++) begin : gen_bank
    ram_bank u_bank (
      .clk          (clk),
      .reset        (reset),
      .req_valid    (bank_valid[i]),
      .req_offset   (bank_offset[i]),
      .req_write    (bank_write[i]),
      .req_wdata    (bank_wdata[i]),
      .clear_en     (clear_en),
      .clear_offset (clear_offset),
      .rd_valid     (bank_rd_valid[i]),
      .rd_data      (bank_rd_data[i])
    );
  end : gen_bank

  // Decoder valids are one-hot or zero, so encode back to a bank number
  always_comb begin
    sel_bank = '0;
    for (int i = 0; i < `RAM_BANKS; i++) begin
      if (bank_valid[i]) begin
        sel_bank = ram_types_pkg::ram_bank_sel_t'(i);
      end
    end
  end

  assign sel_valid = |bank_valid;
  assign sel_write = |(bank_valid & bank_write);

  ram_read_select u_read_select (
    .clk           (clk),
    .reset         (reset),
    .dec_valid     (sel_valid),
    .dec_write     (sel_write),
    .dec_bank      (sel_bank),
    .bank_rd_valid (bank_rd_valid),
    .bank_rd_data  (bank_rd_data),
    .rsp_valid     (rsp_valid),
    .rsp_rdata     (rsp_rdata)
  );

endmodule : banked_ram

// File: rtl/ram_addr_decoder_stage.sv
// Registered one-stage bank decoder; one cycle latency, at most one valid per cycle
`timescale 1ns/1ps
`include "ram_params.svh"

module ram_addr_decoder_stage (
  input  logic                                           clk,
  input  logic                                           reset,
  input  logic                                           in_valid,
  input  ram_types_pkg::ram_addr_t                       in_addr,
  input  logic                                           in_write,
  input  ram_types_pkg::ram_data_t                       in_wdata,
  output logic [`RAM_BANKS-1:0]                          out_valid,
  output ram_types_pkg::ram_offset_t [`RAM_BANKS-1:0]    out_offset,
  output logic [`RAM_BANKS-1:0]                          out_write,
  output ram_types_pkg::ram_data_t [`RAM_BANKS-1:0]      out_wdata
);

  // ------------------------------------------------------------
  // Address split
  // ------------------------------------------------------------

  ram_types_pkg::ram_bank_sel_t in_bank;
  ram_types_pkg::ram_offset_t   in_offset;
  logic [`RAM_BANKS-1:0]        fork_valid;

  // Bank select sits in the top bits
  assign in_bank   = in_addr[`RAM_ADDR_WIDTH-1 -: `RAM_BANK_SEL_WIDTH];
  // Remaining low bits index the word
  assign in_offset = in_addr[`RAM_OFFSET_WIDTH-1:0];

  // ------------------------------------------------------------
  // Per-bank registers
  // ------------------------------------------------------------

  for (genvar i = 0; i < `RAM_BANKS; i++) begin : gen_bank

    // Only the addressed bank sees the request
    assign fork_valid[i] = in_valid && (in_bank == ram_types_pkg::ram_bank_sel_t'(i));

    // Valid is control state
    always_ff @(posedge clk) begin
      if (reset) begin
        out_valid[i] <= 1'b0;
      end else begin
        out_valid[i] <= fork_valid[i];
      end
    end

    // Own copy of the sideband per bank, keeps fanout local
    // Loaded only for the selected bank
    always_ff @(posedge clk) begin
      if (fork_valid[i]) begin
        out_offset[i] <= in_offset;
        out_write[i]  <= in_write;
        out_wdata[i]  <= in_wdata;
      end
    end

  end : gen_bank

endmodule : ram_addr_decoder_stage

// File: rtl/ram_bank.sv
// One flop-array bank; a clear write wins over a request, reads are registered
`timescale 1ns/1ps
`include "ram_params.svh"

module ram_bank (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       req_valid,
  input  ram_types_pkg::ram_offset_t req_offset,
  input  logic                       req_write,
  input  ram_types_pkg::ram_data_t   req_wdata,
  input  logic                       clear_en,
  input  ram_types_pkg::ram_offset_t clear_offset,
  output logic                       rd_valid,
  output ram_types_pkg::ram_data_t   rd_data
);

  // ------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------

  ram_types_pkg::ram_data_t mem [`RAM_BANK_DEPTH];

  // Init sequencer owns the array during a clear
  // Requests never arrive then, dec_valid is held low
  always_ff @(posedge clk) begin
    if (clear_en) begin
      mem[clear_offset] <= '0;
    end else if (req_valid && req_write) begin
      mem[req_offset] <= req_wdata;
    end
  end

  // ------------------------------------------------------------
  // Read port
  // ------------------------------------------------------------

  // One-cycle strobe per read
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= req_valid && !req_write;
    end
  end

  // Data only moves on a read, holds otherwise
  always_ff @(posedge clk) begin
    if (req_valid && !req_write) begin
      rd_data <= mem[req_offset];
    end
  end

endmodule : ram_bank

// File: rtl/ram_ctrl_pkg.sv
// Control definitions of the init sequencer; clear length equals bank depth
`include "ram_params.svh"

package ram_ctrl_pkg;

  // Sequencer states
  // IDLE holds one cycle after reset, CLEAR writes zeros, READY admits requests
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    CLEAR = 2'd1,
    READY = 2'd2
  } init_state_t;

  // One zero write per word, one word per cycle
  localparam int INIT_CYCLES = `RAM_BANK_DEPTH;

endpackage : ram_ctrl_pkg

// File: rtl/ram_init_counter.sv
// Offset walker for the clear; sits at zero when idle and wraps after the last word
`timescale 1ns/1ps
`include "ram_params.svh"

module ram_init_counter (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       clear_en,
  output ram_types_pkg::ram_offset_t clear_offset,
  output logic                       last
);

  // Final word of a bank
  localparam ram_types_pkg::ram_offset_t LAST_OFFSET =
    ram_types_pkg::ram_offset_t'(ram_ctrl_pkg::INIT_CYCLES - 1);

  // Step while clearing, park at zero otherwise
  // Natural wrap after the last word also lands on zero
  always_ff @(posedge clk) begin
    if (reset) begin
      clear_offset <= '0;
    end else if (clear_en) begin
      clear_offset <= clear_offset + 1'b1;
    end else begin
      clear_offset <= '0;
    end
  end

  // Tells the FSM this is the closing clear write
  assign last = (clear_offset == LAST_OFFSET);

endmodule : ram_init_counter

// File: rtl/ram_init_fsm.sv
// Init sequencer; clear takes RAM_BANK_DEPTH cycles, clear strobes during CLEAR are ignored
`timescale 1ns/1ps

module ram_init_fsm (
  input  logic clk,
  input  logic reset,
  input  logic clear,
  input  logic last,
  input  logic req_valid,
  output logic clear_en,
  output logic ready,
  output logic dec_valid
);

  ram_ctrl_pkg::init_state_t state;
  ram_ctrl_pkg::init_state_t state_next;

  // ------------------------------------------------------------
  // Next state
  // ------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      // Single settling cycle after reset
      ram_ctrl_pkg::IDLE: begin
        state_next = ram_ctrl_pkg::CLEAR;
      end
      // Leave once the final word is written
      ram_ctrl_pkg::CLEAR: begin
        if (last) begin
          state_next = ram_ctrl_pkg::READY;
        end
      end
      // Clear strobe restarts the zero fill
      ram_ctrl_pkg::READY: begin
        if (clear) begin
          state_next = ram_ctrl_pkg::CLEAR;
        end
      end
      default: begin
        state_next = ram_ctrl_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ram_ctrl_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  // ------------------------------------------------------------
  // Outputs
  // ------------------------------------------------------------

  // Decoded from the state register
  assign clear_en  = (state == ram_ctrl_pkg::CLEAR);
  assign ready     = (state == ram_ctrl_pkg::READY);

  // Requests outside READY are dropped here
  assign dec_valid = req_valid && ready;

endmodule : ram_init_fsm

// File: rtl/ram_read_select.sv
// Read return mux; relies on a fixed one-cycle bank read latency
`timescale 1ns/1ps
`include "ram_params.svh"

module ram_read_select (
  input  logic                                       clk,
  input  logic                                       reset,
  input  logic                                       dec_valid,
  input  logic                                       dec_write,
  input  ram_types_pkg::ram_bank_sel_t               dec_bank,
  input  logic [`RAM_BANKS-1:0]                      bank_rd_valid,
  input  ram_types_pkg::ram_data_t [`RAM_BANKS-1:0]  bank_rd_data,
  output logic                                       rsp_valid,
  output ram_types_pkg::ram_data_t                   rsp_rdata
);

  logic                         rd_pending;
  ram_types_pkg::ram_bank_sel_t rd_bank;

  // ------------------------------------------------------------
  // Bank tracking
  // ------------------------------------------------------------

  // A read is in its bank cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_pending <= 1'b0;
    end else begin
      rd_pending <= dec_valid && !dec_write;
    end
  end

  // Bank of that read, refreshed per read so back-to-back reads line up
  always_ff @(posedge clk) begin
    if (dec_valid && !dec_write) begin
      rd_bank <= dec_bank;
    end
  end

  // ------------------------------------------------------------
  // Return path
  // ------------------------------------------------------------

  // Straight from the bank registers
  assign rsp_valid = rd_pending && bank_rd_valid[rd_bank];
  assign rsp_rdata = bank_rd_data[rd_bank];

endmodule : ram_read_select

// File: rtl/ram_types_pkg.sv
// Vector types of the banked RAM; widths follow ram_params.svh and change only there
`include "ram_params.svh"

package ram_types_pkg;

  // ------------------------------------------------------------
  // Address side
  // ------------------------------------------------------------

  // Full request address, bank select in the top bits
  typedef logic [`RAM_ADDR_WIDTH-1:0] ram_addr_t;

  // Word index inside one bank
  typedef logic [`RAM_OFFSET_WIDTH-1:0] ram_offset_t;

  // Bank number
  typedef logic [`RAM_BANK_SEL_WIDTH-1:0] ram_bank_sel_t;

  // ------------------------------------------------------------
  // Data side
  // ------------------------------------------------------------

  typedef logic [`RAM_DATA_WIDTH-1:0] ram_data_t;

endpackage : ram_types_pkg

// File: test/tb_banked_ram.sv
// Table-driven banked RAM testbench; assumes two-cycle reads and a 16-cycle clear after reset
`timescale 1ns/1ps
`include "ram_params.svh"

module tb_banked_ram;

  localparam int WORDS      = `RAM_BANKS * `RAM_BANK_DEPTH;
  localparam int OP_WR      = 0;
  localparam int OP_RD      = 1;
  localparam int OP_CLR     = 2;
  // Issued while ready is low, the DUT must drop these
  localparam int OP_WR_DROP = 3;
  localparam int OP_RD_DROP = 4;

  logic                     clk;
  logic                     reset;
  logic                     req_valid;
  logic                     req_write;
  ram_types_pkg::ram_addr_t req_addr;
  ram_types_pkg::ram_data_t req_wdata;
  logic                     clear;
  logic                     ready;
  logic                     rsp_valid;
  ram_types_pkg::ram_data_t rsp_rdata;

  // ------------------------------------------------------------
  // Stimulus table, one queue per column
  // ------------------------------------------------------------
  string                    name_q[$];
  int                       op_q[$];
  ram_types_pkg::ram_addr_t addr_q[$];
  ram_types_pkg::ram_data_t data_q[$];
  // Expected read data, -1 means take it from the reference memory
  int                       exp_q[$];

  // Reads in flight, checked in order
  int                       rsp_due_q[$];
  ram_types_pkg::ram_data_t rsp_exp_q[$];
  string                    rsp_name_q[$];

  ram_types_pkg::ram_data_t ref_mem [WORDS];
  logic [31:0]              lfsr_state;
  int                       cycle_count;
  int                       cycle_limit;
  int                       clear_count;
  int                       errors;

  banked_ram dut (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req_write (req_write),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .clear     (clear),
    .ready     (ready),
    .rsp_valid (rsp_valid),
    .rsp_rdata (rsp_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Galois LFSR x^32 + x^22 + x^2 + x + 1, one step per bit out
  function automatic logic next_lfsr_bit();
    logic bit_out;
    bit_out    = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (bit_out) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return bit_out;
  endfunction

  function automatic ram_types_pkg::ram_data_t rand_word();
    ram_types_pkg::ram_data_t value;
    value = '0;
    for (int b = 0; b < `RAM_DATA_WIDTH; b++) begin
      value = {value[`RAM_DATA_WIDTH-2:0], next_lfsr_bit()};
    end
    return value;
  endfunction

  task automatic add_entry(input string name, input int op,
                           input ram_types_pkg::ram_addr_t addr,
                           input ram_types_pkg::ram_data_t data, input int expected);
    name_q.push_back(name);
    op_q.push_back(op);
    addr_q.push_back(addr);
    data_q.push_back(data);
    exp_q.push_back(expected);
    if (op == OP_CLR) begin
      clear_count++;
    end
  endtask

  task automatic build_table();
    // Power-up clear leaves every word at zero
    for (int a = 0; a < WORDS; a++) begin
      add_entry("reset_zero", OP_RD, ram_types_pkg::ram_addr_t'(a), '0, 0);
    end
    // One word per bank, then back-to-back reads
    add_entry("spread_b0", OP_WR, 6'h03, rand_word(), -1);
    add_entry("spread_b1", OP_WR, 6'h15, rand_word(), -1);
    add_entry("spread_b2", OP_WR, 6'h2a, rand_word(), -1);
    add_entry("spread_b3", OP_WR, 6'h3f, rand_word(), -1);
    add_entry("spread_b0", OP_RD, 6'h03, '0, -1);
    add_entry("spread_b1", OP_RD, 6'h15, '0, -1);
    add_entry("spread_b2", OP_RD, 6'h2a, '0, -1);
    add_entry("spread_b3", OP_RD, 6'h3f, '0, -1);
    // Read right behind a write to the same word
    add_entry("wr_then_rd", OP_WR, 6'h21, 8'h5a, -1);
    add_entry("wr_then_rd", OP_RD, 6'h21, '0, 'h5a);
    add_entry("wr_then_rd_rand", OP_WR, 6'h0c, rand_word(), -1);
    add_entry("wr_then_rd_rand", OP_RD, 6'h0c, '0, -1);
    // Offset 7 in all four banks, select is addr[5:4]
    add_entry("same_offset", OP_WR, 6'h07, 8'h11, -1);
    add_entry("same_offset", OP_WR, 6'h17, 8'h22, -1);
    add_entry("same_offset", OP_WR, 6'h27, 8'h33, -1);
    add_entry("same_offset", OP_WR, 6'h37, 8'h44, -1);
    add_entry("same_offset", OP_RD, 6'h07, '0, 'h11);
    add_entry("same_offset", OP_RD, 6'h17, '0, 'h22);
    add_entry("same_offset", OP_RD, 6'h27, '0, 'h33);
    add_entry("same_offset", OP_RD, 6'h37, '0, 'h44);
    // Clear, then requests that land during CLEAR
    // Dropped write aims at offset 0, which the clear has already passed
    add_entry("clear", OP_CLR, '0, '0, -1);
    add_entry("drop_wr", OP_WR_DROP, 6'h10, 8'hee, -1);
    add_entry("drop_rd", OP_RD_DROP, 6'h07, '0, -1);
    add_entry("after_clear", OP_RD, 6'h10, '0, 0);
    add_entry("after_clear", OP_RD, 6'h17, '0, 0);
    add_entry("after_clear", OP_RD, 6'h07, '0, 0);
    add_entry("after_clear", OP_RD, 6'h2a, '0, 0);
    add_entry("after_clear_wr", OP_WR, 6'h2a, 8'hc3, -1);
    add_entry("after_clear_wr", OP_RD, 6'h2a, '0, 'hc3);
  endtask

  task automatic idle_inputs();
    req_valid <= 1'b0;
    req_write <= 1'b0;
    clear     <= 1'b0;
  endtask

  // ------------------------------------------------------------
  // One table entry, entered and left at a falling edge
  // ------------------------------------------------------------
  task automatic apply_entry(input int i);
    ram_types_pkg::ram_data_t expected;
    if (op_q[i] == OP_WR_DROP || op_q[i] == OP_RD_DROP) begin
      assert (!ready) else begin
        errors++;
        $display("Request %s should be dropped but ready is high", name_q[i]);
      end
    end else begin
      // Idle until the sequencer admits requests
      while (!ready) begin
        @(posedge clk);
        idle_inputs();
        @(negedge clk);
      end
    end
    @(posedge clk);
    idle_inputs();
    case (op_q[i])
      OP_WR, OP_WR_DROP: begin
        req_valid <= 1'b1;
        req_write <= 1'b1;
        req_addr  <= addr_q[i];
        req_wdata <= data_q[i];
      end
      OP_RD, OP_RD_DROP: begin
        req_valid <= 1'b1;
        req_addr  <= addr_q[i];
      end
      OP_CLR: begin
        clear <= 1'b1;
      end
      default: begin
      end
    endcase
    // Reference model follows accepted requests only
    if (op_q[i] == OP_WR) begin
      ref_mem[addr_q[i]] = data_q[i];
    end
    expected = (exp_q[i] < 0) ? ref_mem[addr_q[i]] : ram_types_pkg::ram_data_t'(exp_q[i]);
    if (op_q[i] == OP_CLR) begin
      foreach (ref_mem[a]) begin
        ref_mem[a] = '0;
      end
      @(posedge clk);
      idle_inputs();
    end
    @(negedge clk);
    // Response lands two edges after the DUT samples the read
    if (op_q[i] == OP_RD) begin
      rsp_due_q.push_back(cycle_count + 2);
      rsp_exp_q.push_back(expected);
      rsp_name_q.push_back(name_q[i]);
    end
    if (op_q[i] == OP_CLR) begin
      assert (!ready) else begin
        errors++;
        $display("ready stayed high after the clear strobe");
      end
    end
  endtask

  // ------------------------------------------------------------
  // Cycle counter, watchdog and response checker
  // ------------------------------------------------------------
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles, the table did not complete", cycle_count);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  always @(negedge clk) begin
    if (!reset) begin
      if (rsp_due_q.size() > 0 && rsp_due_q[0] == cycle_count) begin
        assert (rsp_valid) else begin
          errors++;
          $display("No rsp_valid for read %s at cycle %0d", rsp_name_q[0], cycle_count);
        end
        if (rsp_valid) begin
          assert (rsp_rdata === rsp_exp_q[0]) else begin
            errors++;
            $display("[ERROR] %s expected %h actual %h", rsp_name_q[0], rsp_exp_q[0],
                     rsp_rdata);
          end
        end
        void'(rsp_due_q.pop_front());
        void'(rsp_exp_q.pop_front());
        void'(rsp_name_q.pop_front());
      end else begin
        assert (!rsp_valid) else begin
          errors++;
          $display("Unexpected rsp_valid at cycle %0d with no read due", cycle_count);
        end
      end
    end
  end

  initial begin
    errors      = 0;
    cycle_count = 0;
    clear_count = 0;
    lfsr_state  = 32'd98856;
    reset       = 1'b1;
    req_valid   = 1'b0;
    req_write   = 1'b0;
    req_addr    = '0;
    req_wdata   = '0;
    clear       = 1'b0;
    foreach (ref_mem[a]) begin
      ref_mem[a] = '0;
    end
    build_table();
    cycle_limit = 10 + 2 * (name_q.size() + 20 * clear_count) + 50;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    for (int i = 0; i < name_q.size(); i++) begin
      apply_entry(i);
    end
    @(posedge clk);
    idle_inputs();
    // Drain, then watch a few quiet cycles
    while (rsp_due_q.size() > 0) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
    $display("Run complete: %0d entries, %0d errors", name_q.size(), errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule : tb_banked_ram
